// ==== common/pd_cfg.svh ====
////////////////////////////////////////
// Pre-decode configuration
////////////////////////////////////////

`ifndef PD_CFG_SVH
`define PD_CFG_SVH

`define PD_LANES       4          // Decode lanes
`define PD_RES_DEPTH   8          // Result FIFO entries

`define PD_ADDR_INSTR  8'h00      // W  issues an instruction word
`define PD_ADDR_FLAGS  8'h04      // RW R0 flags, P, Q
`define PD_ADDR_RESULT 8'h08      // R  pops result FIFO head
`define PD_ADDR_STATUS 8'h0c      // R  FIFO count and lanes in flight

`endif

// ==== common/pd_pkg.sv ====
////////////////////////////////////////
// Pre-decode types
////////////////////////////////////////

package pd_pkg;

	typedef logic [0:15] instr_t;    // Bit 0 is the MSB as in the CPU docs
	typedef logic [0:8]  r0_t;       // Z M V C L E G Y X
	typedef logic [3:0]  tag_t;      // Issue sequence number
	typedef logic [15:0] res_t;      // {class, xi, nef, c0, b0, d, a, tag}

	// Opcode groups
	typedef enum logic [3:0] {
		CL_ILLEGAL = 4'd0,            // 000..017
		CL_NORM    = 4'd1,            // 020..034, 040..057
		CL_INOU    = 4'd2,            // 035 OU, 036 IN
		CL_FP      = 4'd3,            // 037
		CL_KA1     = 4'd4,            // 060..067
		CL_JS      = 4'd5,            // 070
		CL_KA2     = 4'd6,            // 071
		CL_C       = 4'd7,            // 072
		CL_S       = 4'd8,            // 073
		CL_J       = 4'd9,            // 074
		CL_L       = 4'd10,           // 075
		CL_G       = 4'd11,           // 076
		CL_BN      = 4'd12            // 077
	} pd_class_t;

	typedef enum logic [1:0] {
		LANE_IDLE   = 2'd0,           // Free for a new word
		LANE_DECODE = 2'd1,           // IR loaded, decoding
		LANE_FULL   = 2'd2            // Result waiting for retire
	} lane_state_t;

endpackage

// ==== flist.f ====
+incdir+common
common/pd_pkg.sv
hw/decode/pd_lane.sv
hw/pd_issue.sv
hw/pd_retire.sv
hw/pd_top.sv
tests/pd_tb_clk.sv
tests/pd_sva.sv
tests/pd_tb.sv

// ==== hw/decode/pd_lane.sv ====
////////////////////////////////////////
// Pre-decode lane
////////////////////////////////////////

module pd_lane import pd_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   ld,                // Load strobe from issue
	input  instr_t instr,             // Shared issue bus
	input  r0_t    r0,
	input  logic   p,                 // Skip flag
	input  logic   q,                 // User mode
	input  tag_t   tag,
	output logic   busy,              // Load until take
	output logic   done,              // Result valid
	output res_t   res,
	input  logic   take               // Retire accepted res
);

	lane_state_t state;

	instr_t ir;                       // Instruction register
	r0_t    ir_r0;                    // Flags captured with IR
	logic   ir_p;
	logic   ir_q;
	tag_t   ir_tag;

	pd_class_t  cls;
	logic [0:5] opc;
	logic [0:2] fa;                   // A field
	logic       xi;
	logic       nef;
	logic       jmp_fail;             // Condition of J/JS not met
	res_t       res_q;

	assign opc = ir[0:5];
	assign fa  = ir[7:9];

	// Opcode group
	always_comb begin
		case (opc) inside
			[6'o00:6'o17]: cls = CL_ILLEGAL;
			[6'o20:6'o34],
			[6'o40:6'o57]: cls = CL_NORM;
			6'o35, 6'o36:  cls = CL_INOU;     // OU, IN
			6'o37:         cls = CL_FP;
			[6'o60:6'o67]: cls = CL_KA1;
			6'o70:         cls = CL_JS;
			6'o71:         cls = CL_KA2;
			6'o72:         cls = CL_C;
			6'o73:         cls = CL_S;
			6'o74:         cls = CL_J;
			6'o75:         cls = CL_L;
			6'o76:         cls = CL_G;
			default:       cls = CL_BN;
		endcase
	end

	// Conditional jumps against R0
	always_comb begin
		jmp_fail = 1'b0;
		if (cls == CL_J) begin
			case (fa)
				3'd1:    jmp_fail = !ir_r0[4];   // JL
				3'd2:    jmp_fail = !ir_r0[5];   // JE
				3'd3:    jmp_fail = !ir_r0[6];   // JG
				3'd4:    jmp_fail = !ir_r0[0];   // JZ
				3'd5:    jmp_fail = !ir_r0[1];   // JM
				3'd6:    jmp_fail = ir_r0[5];    // JN
				default: jmp_fail = 1'b0;        // UJ, LJ
			endcase
		end else if (cls == CL_JS) begin
			case (fa)
				3'd4:    jmp_fail = !ir_r0[2];   // JVS
				3'd5:    jmp_fail = !ir_r0[8];   // JXS
				3'd6:    jmp_fail = !ir_r0[7];   // JYS
				3'd7:    jmp_fail = !ir_r0[3];   // JCS
				default: jmp_fail = 1'b0;
			endcase
		end
	end

	// Illegal for empty opcodes, user mode IN/OU/S and unused S codes
	assign xi = (cls == CL_ILLEGAL)
		|| (ir_q && (cls == CL_INOU || cls == CL_S))
		|| (cls == CL_S && fa >= 3'd5);
	assign nef = xi || ir_p || jmp_fail;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= LANE_IDLE;
		end else begin
			case (state)
				LANE_IDLE:   if (ld) state <= LANE_DECODE;
				LANE_DECODE: state <= LANE_FULL;
				LANE_FULL:   if (take) state <= LANE_IDLE;
				default:     state <= LANE_IDLE;
			endcase
		end
	end

	// IR and captured flags
	always_ff @(posedge clk) begin
		if (state == LANE_IDLE && ld) begin
			ir     <= instr;
			ir_r0  <= r0;
			ir_p   <= p;
			ir_q   <= q;
			ir_tag <= tag;
		end
	end

	// Result hold register
	always_ff @(posedge clk) begin
		if (state == LANE_DECODE)
			res_q <= {cls, xi, nef, (ir[13:15] == 3'd0), (ir[10:12] == 3'd0), ir[6], fa, ir_tag};
	end

	assign busy = ld || (state != LANE_IDLE);  // Covers the load cycle too
	assign done = (state == LANE_FULL);
	assign res  = res_q;

endmodule

// ==== hw/pd_issue.sv ====
////////////////////////////////////////
// APB front end and dispatch
////////////////////////////////////////

`include "pd_cfg.svh"

module pd_issue import pd_pkg::*; (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          psel,
	input  logic                          penable,
	input  logic                          pwrite,
	input  logic [7:0]                    paddr,
	input  logic [31:0]                   pwdata,
	output logic [31:0]                   prdata,
	output logic                          pready,
	output logic                          pslverr,
	input  logic [`PD_LANES-1:0]          busy,
	output logic [`PD_LANES-1:0]          ld,         // One-hot load
	output instr_t                        instr,
	output r0_t                           r0,
	output logic                          p,
	output logic                          q,
	output tag_t                          tag,
	input  res_t                          fifo_head,
	input  logic [$clog2(`PD_RES_DEPTH):0] fifo_count,
	output logic                          pop
);

	localparam int PW = $clog2(`PD_LANES);

	logic [PW-1:0] dptr;                              // Round-robin dispatch
	tag_t          tag_cnt;
	logic          access;
	logic          is_instr, is_flags, is_result, is_status;
	logic          mapped;
	logic          fifo_empty;
	logic          issue;
	logic [PW:0]   inflight;

	assign access     = psel && penable;
	assign is_instr   = (paddr == `PD_ADDR_INSTR);
	assign is_flags   = (paddr == `PD_ADDR_FLAGS);
	assign is_result  = (paddr == `PD_ADDR_RESULT);
	assign is_status  = (paddr == `PD_ADDR_STATUS);
	assign mapped     = is_instr || is_flags || is_result || is_status;
	assign fifo_empty = (fifo_count == '0);

	// Only an INSTR write to a busy lane waits
	assign pready  = !(access && pwrite && is_instr && busy[dptr]);
	assign issue   = access && pwrite && is_instr && !busy[dptr];
	assign pop     = access && !pwrite && is_result && !fifo_empty;
	assign pslverr = access && (!mapped || (!pwrite && is_result && fifo_empty));

	// Lanes in flight
	always_comb begin
		inflight = '0;
		for (int i = 0; i < `PD_LANES; i++)
			inflight = inflight + (PW+1)'(busy[i]);
	end

	always_comb begin
		prdata = '0;
		if (access && !pwrite) begin
			if (is_result && !fifo_empty)
				prdata[15:0] = fifo_head;
			else if (is_status)
				prdata[7:0] = {4'(inflight), 4'(fifo_count)};
			else if (is_flags)
				prdata[10:0] = {q, p, r0};           // Z ends up in bit 8
		end
	end

	// Flag latch, pointer, tag
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			r0      <= '0;
			p       <= 1'b0;
			q       <= 1'b0;
			dptr    <= '0;
			tag_cnt <= '0;
			ld      <= '0;
		end else begin
			ld <= '0;
			if (access && pwrite && is_flags) begin
				r0 <= pwdata[8:0];
				p  <= pwdata[9];
				q  <= pwdata[10];
			end
			if (issue) begin
				ld[dptr] <= 1'b1;
				dptr     <= dptr + 1'b1;          // Lane count is a power of two
				tag_cnt  <= tag_cnt + 1'b1;       // Wraps at 16
			end
		end
	end

	// Issue bus payload
	always_ff @(posedge clk) begin
		if (issue) begin
			instr <= pwdata[15:0];
			tag   <= tag_cnt;
		end
	end

endmodule

// ==== hw/pd_retire.sv ====
////////////////////////////////////////
// In-order retire and result FIFO
////////////////////////////////////////

`include "pd_cfg.svh"

module pd_retire import pd_pkg::*; (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [`PD_LANES-1:0]          done,
	input  res_t                          res [`PD_LANES],
	output logic [`PD_LANES-1:0]          take,
	input  logic                          pop,        // APB RESULT read
	output res_t                          fifo_head,
	output logic [$clog2(`PD_RES_DEPTH):0] fifo_count
);

	localparam int PW = $clog2(`PD_LANES);
	localparam int DW = $clog2(`PD_RES_DEPTH);
	localparam logic [DW:0] DEPTH = `PD_RES_DEPTH;

	logic [PW-1:0] rptr;                       // Next lane in issue order
	logic [DW-1:0] head;
	logic [DW-1:0] tail;
	logic [DW:0]   count;
	logic          full;
	logic          push;
	res_t          mem [`PD_RES_DEPTH];

	assign full = (count == DEPTH);
	assign push = done[rptr] && !full;

	always_comb begin
		take       = '0;
		take[rptr] = push;                   // At most one lane per cycle
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rptr  <= '0;
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (push) begin
				rptr <= rptr + 1'b1;
				tail <= tail + 1'b1;            // Depth is a power of two
			end
			if (pop)
				head <= head + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// FIFO storage
	always_ff @(posedge clk) begin
		if (push)
			mem[tail] <= res[rptr];
	end

	assign fifo_head  = mem[head];
	assign fifo_count = count;

endmodule

// ==== hw/pd_top.sv ====
////////////////////////////////////////
// Pre-decode unit top
////////////////////////////////////////

`include "pd_cfg.svh"

module pd_top import pd_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [7:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);

	logic [`PD_LANES-1:0]           busy;
	logic [`PD_LANES-1:0]           ld;
	logic [`PD_LANES-1:0]           done;
	logic [`PD_LANES-1:0]           take;
	instr_t                         instr;         // Shared issue bus
	r0_t                            r0;
	logic                           p;
	logic                           q;
	tag_t                           tag;
	res_t                           res [`PD_LANES];
	res_t                           fifo_head;
	logic [$clog2(`PD_RES_DEPTH):0] fifo_count;
	logic                           pop;

	pd_issue u_issue (
		.clk(clk), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.busy(busy), .ld(ld), .instr(instr), .r0(r0), .p(p), .q(q), .tag(tag),
		.fifo_head(fifo_head), .fifo_count(fifo_count), .pop(pop)
	);

	for (genvar i = 0; i < `PD_LANES; i++) begin : g_lane
		pd_lane u_lane (
			.clk(clk), .rst_n(rst_n),
			.ld(ld[i]), .instr(instr), .r0(r0), .p(p), .q(q), .tag(tag),
			.busy(busy[i]), .done(done[i]), .res(res[i]), .take(take[i])
		);
	end

	pd_retire u_retire (
		.clk(clk), .rst_n(rst_n),
		.done(done), .res(res), .take(take),
		.pop(pop), .fifo_head(fifo_head), .fifo_count(fifo_count)
	);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the pre-decode unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module pd_tb \
	-f flist.f \
	-o pd_sim

./obj_dir/pd_sim | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi

// ==== tests/pd_sva.sv ====
////////////////////////////////////////
// APB and lane assertions
////////////////////////////////////////

`include "pd_cfg.svh"

module pd_sva (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 pready,
	input logic                 pslverr,
	input logic [31:0]          prdata,
	input logic [`PD_LANES-1:0] ld,
	input logic [`PD_LANES-1:0] done,
	input logic [`PD_LANES-1:0] take
);

	a_err_ready: assert property (@(posedge clk) disable iff (!rst_n)
		pslverr |-> pready)
		else $error("pslverr raised while pready is low");

	a_rdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
		!pready |=> (pready || $stable(prdata)))
		else $error("prdata changed during a wait state");

	// Load, IR latch, then result
	for (genvar i = 0; i < `PD_LANES; i++) begin : g_done
		a_done_late: assert property (@(posedge clk) disable iff (!rst_n)
			done[i] |-> (!ld[i] && !$past(ld[i])))
			else $error("lane %0d done within two cycles of its load", i);
	end

	a_take_one: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(take))
		else $error("more than one lane taken in a cycle");

endmodule

bind pd_top pd_sva u_sva (
	.clk(clk), .rst_n(rst_n), .pready(pready), .pslverr(pslverr), .prdata(prdata),
	.ld(ld), .done(done), .take(take)
);

// ==== tests/pd_tb.sv ====
////////////////////////////////////////
// Pre-decode unit testbench
////////////////////////////////////////

`include "pd_cfg.svh"

module pd_tb import pd_pkg::*; ();

	localparam int N_INSTR = 200 + 36 + 25 + 13 + 4;  // Words issued by all tests
	localparam int LIMIT   = N_INSTR * 40 + 2000;

	logic        clk;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	logic [31:0] lfsr;
	logic [8:0]  f_r0;                    // Model flags with Z at bit 8
	logic        f_p;
	logic        f_q;
	logic [3:0]  next_tag;
	logic [15:0] exp_q [$];               // Expected results in issue order
	int          errors;
	int          checks;
	int          tests;
	int          cycles;

	pd_tb_clk u_clk (.clk(clk), .rst_n(rst_n));

	pd_top dut (
		.clk(clk), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	// Fibonacci LFSR on x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	// Half the words land in 060..077
	function automatic logic [15:0] rand_word();
		logic [5:0] op;
		if (rand_bits(1) == 32'd1)
			op = 6'o60 + 6'(rand_bits(4));
		else
			op = 6'(rand_bits(6));
		return {op, 10'(rand_bits(10))};
	endfunction

	function automatic logic [3:0] class_of(input logic [5:0] op);
		if (op < 6'o20)
			return CL_ILLEGAL;
		if (op == 6'o35 || op == 6'o36)
			return CL_INOU;
		if (op == 6'o37)
			return CL_FP;
		if (op < 6'o60)
			return CL_NORM;
		if (op < 6'o70)
			return CL_KA1;
		case (op)
			6'o70:   return CL_JS;
			6'o71:   return CL_KA2;
			6'o72:   return CL_C;
			6'o73:   return CL_S;
			6'o74:   return CL_J;
			6'o75:   return CL_L;
			6'o76:   return CL_G;
			default: return CL_BN;
		endcase
	endfunction

	// Expected result word for w under the current model flags and tag
	function automatic logic [15:0] model(input logic [15:0] w);
		logic [3:0] cl;
		logic [2:0] a;
		logic       z, m, v, c, l, e, g, y, x;
		logic       go;
		logic       xi;
		logic       nef;
		cl = class_of(w[15:10]);
		a  = w[8:6];
		{z, m, v, c, l, e, g, y, x} = f_r0;
		go = 1'b1;
		if (cl == CL_J) begin
			case (a)
				3'd1:    go = l;
				3'd2:    go = e;
				3'd3:    go = g;
				3'd4:    go = z;
				3'd5:    go = m;
				3'd6:    go = !e;
				default: go = 1'b1;
			endcase
		end else if (cl == CL_JS) begin
			case (a)
				3'd4:    go = v;
				3'd5:    go = x;
				3'd6:    go = y;
				3'd7:    go = c;
				default: go = 1'b1;
			endcase
		end
		xi = (cl == CL_ILLEGAL) || (f_q && (cl == CL_INOU || cl == CL_S))
			|| (cl == CL_S && a > 3'd4);
		nef = xi || f_p || !go;
		return {cl, xi, nef, w[2:0] == 3'd0, w[5:3] == 3'd0, w[9], a, next_tag};
	endfunction

	// Flag tested by a conditional jump
	function automatic logic [8:0] cond_mask(input logic js, input logic [2:0] a);
		if (!js) begin
			case (a)
				3'd1:    return 9'h010;     // L
				3'd2:    return 9'h008;     // E
				3'd3:    return 9'h004;     // G
				3'd4:    return 9'h100;     // Z
				3'd5:    return 9'h080;     // M
				3'd6:    return 9'h008;     // E
				default: return 9'h000;
			endcase
		end
		case (a)
			3'd4:    return 9'h040;         // V
			3'd5:    return 9'h001;         // X
			3'd6:    return 9'h002;         // Y
			3'd7:    return 9'h020;         // C
			default: return 9'h000;
		endcase
	endfunction

	task automatic check(input logic [31:0] want, input logic [31:0] got, input string what);
		checks++;
		if (want !== got) begin
			errors++;
			$display("[ERROR] %0t %s: expected %h, got %h", $time, what, want, got);
		end
	endtask

	task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		@(posedge clk);
		psel    <= 1'b1;                  // Setup phase
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		while (!pready)
			@(posedge clk);
		rdata = prdata;
		err   = pslverr;
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] d;
		logic        e;
		apb_access(1'b1, addr, data, d, e);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] d, output logic e);
		apb_access(1'b0, addr, 32'h0, d, e);
	endtask

	task automatic set_flags(input logic [8:0] r, input logic pv, input logic qv);
		f_r0 = r;
		f_p  = pv;
		f_q  = qv;
		apb_write(`PD_ADDR_FLAGS, {21'h0, qv, pv, r});
	endtask

	task automatic issue_word(input logic [15:0] w);
		exp_q.push_back(model(w));
		apb_write(`PD_ADDR_INSTR, {16'h0, w});
		next_tag = next_tag + 4'd1;
	endtask

	task automatic read_status(output int cnt, output int inf);
		logic [31:0] d;
		logic        e;
		apb_read(`PD_ADDR_STATUS, d, e);
		check(32'd0, 32'(e), "STATUS read error");
		cnt = 32'(d[3:0]);
		inf = 32'(d[7:4]);
	endtask

	// Poll STATUS until the FIFO holds n results
	task automatic wait_results(input int n);
		int cnt;
		int inf;
		read_status(cnt, inf);
		while (cnt < n)
			read_status(cnt, inf);
	endtask

	task automatic take_result(output logic [15:0] r);
		logic [31:0] d;
		logic        e;
		logic [15:0] want;
		wait_results(1);
		apb_read(`PD_ADDR_RESULT, d, e);
		check(32'd0, 32'(e), "RESULT read error");
		r    = d[15:0];
		want = exp_q.pop_front();
		check(32'(want), 32'(r), $sformatf("result of tag %0d", want[3:0]));
	endtask

	task automatic decode_one(input logic [15:0] w, output logic [15:0] r);
		issue_word(w);
		take_result(r);
	endtask

	// Hold an INSTR write for n cycles, then drop it
	task automatic stall_probe(input logic [15:0] w, input int n);
		int low;
		low = 0;
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= `PD_ADDR_INSTR;
		pwdata  <= {16'h0, w};
		@(posedge clk);
		penable <= 1'b1;
		repeat (n) begin
			@(posedge clk);
			if (!pready)
				low++;
		end
		psel    <= 1'b0;                  // Frees the bus for a RESULT read
		penable <= 1'b0;
		check(n, low, "pready held low with all lanes full");
	endtask

	task automatic end_test(input string name, input int err0);
		tests++;
		$display("%s finished with %0d errors", name, errors - err0);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout: the tests did not finish within %0d cycles", LIMIT);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial begin
		logic [15:0] w;
		logic [15:0] r;
		logic [15:0] words [3];
		logic [31:0] d;
		logic        e;
		logic [8:0]  base;
		logic [8:0]  mask;
		logic [8:0]  fl;
		logic        pv;
		logic        qv;
		int          err0;
		int          cnt;
		int          inf;
		int          n;
		lfsr     = 32'hfc66;
		f_r0     = '0;
		f_p      = 1'b0;
		f_q      = 1'b0;
		next_tag = '0;
		errors   = 0;
		checks   = 0;
		tests    = 0;
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= '0;
		pwdata  <= '0;
		wait (rst_n === 1'b1);

		// Decode of random words under random flags
		err0 = errors;
		for (int i = 0; i < 200; i++) begin
			fl = 9'(rand_bits(9));
			pv = 1'(rand_bits(1));
			qv = 1'(rand_bits(1));
			set_flags(fl, pv, qv);
			decode_one(rand_word(), r);
		end
		end_test("decode", err0);

		// Each jump condition met and then not met
		err0 = errors;
		for (int js = 0; js < 2; js++) begin
			for (int a = 0; a < 8; a++) begin
				for (int s = 1; s >= 0; s--) begin
					base = 9'(rand_bits(9));
					mask = cond_mask(1'(js), 3'(a));
					set_flags(s != 0 ? (base | mask) : (base & ~mask), 1'b0, 1'b0);
					w = {js != 0 ? 6'o70 : 6'o74, 1'(rand_bits(1)), 3'(a), 6'(rand_bits(6))};
					decode_one(w, r);
				end
			end
		end
		set_flags(9'h1ff, 1'b1, 1'b0);      // Every jump would be taken
		for (int k = 0; k < 4; k++) begin
			w = {k[1] ? 6'o20 + 6'(k) : 6'o70 + 6'(k * 4), 1'b0, 3'd0, 6'(rand_bits(6))};
			decode_one(w, r);
			check(32'd1, 32'(r[10]), "P forces NEF");
		end
		end_test("jumps", err0);

		// Illegal and privileged words
		err0 = errors;
		set_flags(9'(rand_bits(9)), 1'b0, 1'b0);
		for (int op = 0; op < 16; op++) begin
			decode_one({6'(op), 10'(rand_bits(10))}, r);
			check(32'd3, 32'(r[11:10]), "empty opcode XI and NEF");
		end
		for (int a = 5; a < 8; a++) begin
			decode_one({6'o73, 1'(rand_bits(1)), 3'(a), 6'(rand_bits(6))}, r);
			check(32'd3, 32'(r[11:10]), "unused S code XI and NEF");
		end
		words[0] = {6'o35, 1'(rand_bits(1)), 3'(rand_bits(3)), 6'(rand_bits(6))};
		words[1] = {6'o36, 1'(rand_bits(1)), 3'(rand_bits(3)), 6'(rand_bits(6))};
		words[2] = {6'o73, 1'(rand_bits(1)), 3'(rand_bits(2)), 6'(rand_bits(6))};
		for (int qs = 1; qs >= 0; qs--) begin
			set_flags(9'(rand_bits(9)), 1'b0, 1'(qs));
			for (int k = 0; k < 3; k++) begin
				decode_one(words[k], r);
				check(32'(qs), 32'(r[11]), "XI of IN/OU/S under Q");
				if (qs != 0)
					check(32'd1, 32'(r[10]), "NEF of IN/OU/S under Q");
			end
		end
		end_test("illegal", err0);

		// Fill every lane and FIFO entry and stall one more
		err0 = errors;
		for (int i = 0; i < 12; i++)
			issue_word(rand_word());
		wait_results(8);
		read_status(cnt, inf);
		check(32'd8, cnt, "FIFO count when full");
		check(32'd4, inf, "lanes in flight when full");
		w = rand_word();
		stall_probe(w, 10);
		take_result(r);
		issue_word(w);
		for (int i = 0; i < 12; i++)
			take_result(r);
		end_test("backpressure", err0);

		// Error responses and status counts
		err0 = errors;
		read_status(cnt, inf);
		check(32'd0, cnt, "FIFO count when idle");
		check(32'd0, inf, "lanes in flight when idle");
		apb_read(`PD_ADDR_RESULT, d, e);
		check(32'd1, 32'(e), "empty RESULT read error");
		check(32'd0, d, "empty RESULT read data");
		apb_read(8'h10, d, e);
		check(32'd1, 32'(e), "unmapped read error");
		check(32'd0, d, "unmapped read data");
		apb_access(1'b1, 8'h14, 32'h1234, d, e);
		check(32'd1, 32'(e), "unmapped write error");
		apb_read(`PD_ADDR_FLAGS, d, e);
		check(32'd0, 32'(e), "FLAGS read error");
		check(32'({f_q, f_p, f_r0}), d, "FLAGS readback");
		n = 1 + 32'(rand_bits(2));
		for (int i = 0; i < n; i++)
			issue_word(rand_word());
		wait_results(n);
		read_status(cnt, inf);
		check(n, cnt, "FIFO count after writes");
		check(32'd0, inf, "lanes in flight after retire");
		take_result(r);
		read_status(cnt, inf);
		check(n - 1, cnt, "FIFO count after one read");
		for (int i = 1; i < n; i++)
			take_result(r);
		end_test("status", err0);

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== tests/pd_tb_clk.sv ====
////////////////////////////////////////
// Testbench clock and reset
////////////////////////////////////////

module pd_tb_clk (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;            // Period 20
	end

	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule
